// File: sources.f
+incdir+common
common/backproj_pkg.sv
verilog/angle_sequencer.sv
sino_fetch/sino_line_fetcher.sv
sino_fetch/ramp_filter.sv
verilog/filtered_line_buffer.sv
verilog/backproj_sino_top.sv
test/backproj_checker.sv
test/tb_backproj_sino.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it, and scans the log
cd "$(dirname "$0")" || exit 1
set -o pipefail
rm -f sim.log

verilator --binary --timing -f sources.f --top-module tb_backproj_sino -o tb_sim \
    && ./obj_dir/tb_sim 2>&1 | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }

grep -q "Test failed" sim.log && exit 1 || exit 0

// File: test/tb_backproj_sino.sv
`timescale 1ns/100ps
`include "backproj_cfg.svh"

module tb_backproj_sino
    import backproj_pkg::*;
();

    localparam int     IMAGE_SIZE = `NO_OF_ANGLES * `LINE_SIZE;
    localparam int     WAIT_LIMIT = 4 * `LINE_SIZE;
    localparam int     NO_OF_ROWS = 3;
    localparam int     LAST_ACKS  = `NO_OF_ANGLES - 1;
    localparam angle_t LAST_ANGLE = angle_t'((`NO_OF_ANGLES - 1) * `ANGLE_STEP);

    // one row per run with kick, next_angle delay, stray kick, expected acks and final angle
    typedef struct packed {
        logic   kick;
        int     next_delay;
        logic   stray_kick;
        int     acks;
        angle_t last_angle;
    } row_t;

    logic      clk = 1'b0;
    logic      reset_n;
    logic      kick;
    logic      next_angle;
    s_t        rd_s;
    // memory model output starts at zero
    sample_t   sg_data = '0;
    logic      done;
    logic      line_valid;
    angle_t    angle;
    logic      next_angle_ack;
    filtered_t rd_data;
    sg_addr_t  sg_addr;
    logic      sg_rd;

    logic      rd_active;
    int        exp_acks;
    angle_t    exp_last_angle;
    int        chk_errors;
    int        timeouts;
    logic      aborted;
    int        i;

    sample_t   image [IMAGE_SIZE];
    row_t      table_rows [NO_OF_ROWS];
    logic      mem_rd;
    sg_addr_t  mem_addr;

    always #4 clk = ~clk;

    backproj_sino_top dut (
        .clk            (clk),
        .reset_n        (reset_n),
        .kick           (kick),
        .next_angle     (next_angle),
        .rd_s           (rd_s),
        .sg_data        (sg_data),
        .done           (done),
        .line_valid     (line_valid),
        .angle          (angle),
        .next_angle_ack (next_angle_ack),
        .rd_data        (rd_data),
        .sg_addr        (sg_addr),
        .sg_rd          (sg_rd)
    );

    backproj_checker chk (
        .clk            (clk),
        .reset_n        (reset_n),
        .image          (image),
        .rd_active      (rd_active),
        .exp_acks       (exp_acks),
        .exp_last_angle (exp_last_angle),
        .rd_s           (rd_s),
        .done           (done),
        .line_valid     (line_valid),
        .angle          (angle),
        .next_angle_ack (next_angle_ack),
        .rd_data        (rd_data),
        .sg_addr        (sg_addr),
        .sg_rd          (sg_rd),
        .error_count    (chk_errors)
    );

    // sinogram memory returns data one cycle after the read
    always
    begin
        @(negedge clk);
        mem_rd   = sg_rd;
        mem_addr = sg_addr;
        @(posedge clk);
        #1;
        if (mem_rd)
            sg_data = image[mem_addr];
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fill_image;
        logic [31:0] r;
        r = 32'haf2e;
        for (int n = 0; n < IMAGE_SIZE; n++)
        begin
            r = xorshift(r);
            image[n] = r[`SAMPLE_WIDTH-1:0];
        end
    endtask

    // inputs change 1 ns after the edge
    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_line_valid;
        int n;
        n = 0;
        while (!line_valid && n < WAIT_LIMIT)
        begin
            next_cycle();
            n++;
        end
        if (!line_valid)
        begin
            timeouts++;
            aborted = 1'b1;
            $display("timeout at %0t: line_valid never rose after kick", $time);
        end
    endtask

    task automatic wait_ack_or_done;
        int n;
        n = 0;
        while (!next_angle_ack && !done && n < WAIT_LIMIT)
        begin
            next_cycle();
            n++;
        end
        if (!next_angle_ack && !done)
        begin
            timeouts++;
            aborted = 1'b1;
            $display("timeout at %0t: no next_angle_ack or done while next_angle was high",
                     $time);
        end
    endtask

    // consumer sweeps s over the whole front line
    task automatic read_line;
        for (int s = 0; s < `LINE_SIZE; s++)
        begin
            rd_s      = s_t'(s);
            rd_active = 1'b1;
            next_cycle();
        end
        rd_active = 1'b0;
    endtask

    task automatic run_row(input int idx);
        row_t row;
        row            = table_rows[idx];
        exp_acks       = row.acks;
        exp_last_angle = row.last_angle;
        if (row.kick)
        begin
            kick = 1'b1;
            next_cycle();
            kick = 1'b0;
        end
        wait_line_valid();
        if (aborted)
            return;
        for (int a = 0; a < `NO_OF_ANGLES; a++)
        begin
            // front bank flips one cycle after the swap strobe
            next_cycle();
            // sequencer is in work_s here and must ignore the kick
            if (row.stray_kick && a == 3)
            begin
                kick = 1'b1;
                next_cycle();
                kick = 1'b0;
            end
            read_line();
            repeat (row.next_delay) next_cycle();
            next_angle = 1'b1;
            wait_ack_or_done();
            next_angle = 1'b0;
            if (aborted)
                return;
        end
    endtask

    initial
    begin
        reset_n        = 1'b0;
        kick           = 1'b0;
        next_angle     = 1'b0;
        rd_s           = '0;
        rd_active      = 1'b0;
        exp_acks       = 0;
        exp_last_angle = '0;
        timeouts       = 0;
        aborted        = 1'b0;
        // delay 0 keeps next_angle waiting on the running fill
        table_rows[0] = '{1'b1, 0, 1'b0, LAST_ACKS, LAST_ANGLE};
        table_rows[1] = '{1'b1, 6, 1'b1, LAST_ACKS, LAST_ANGLE};
        // fill long done when next_angle comes
        table_rows[2] = '{1'b1, 24, 1'b0, LAST_ACKS, LAST_ANGLE};
        fill_image();

        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b1;
        next_cycle();

        for (i = 0; i < NO_OF_ROWS; i++)
        begin
            if (!aborted)
                run_row(i);
        end
        // let the last reads drain through the checker
        repeat (3) next_cycle();

        $display("errors: %0d from the checker, %0d timeouts", chk_errors, timeouts);
        if (chk_errors == 0 && timeouts == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: test/backproj_checker.sv
`timescale 1ns/100ps
`include "backproj_cfg.svh"

module backproj_checker
    import backproj_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  sample_t   image [`NO_OF_ANGLES * `LINE_SIZE],
    input  logic      rd_active,
    input  int        exp_acks,
    input  angle_t    exp_last_angle,
    input  s_t        rd_s,
    input  logic      done,
    input  logic      line_valid,
    input  angle_t    angle,
    input  logic      next_angle_ack,
    input  filtered_t rd_data,
    input  sg_addr_t  sg_addr,
    input  logic      sg_rd,
    output int        error_count
);

    int   errors = 0;
    // reads in this run, doubles as the next expected address
    int   read_cnt = 0;
    int   burst_len = 0;
    logic sg_rd_q = 1'b0;
    // cycles since the newest fill issued its first read
    int   fill_age = 1000;
    int   ack_cnt = 0;
    int   exp_angle = 0;
    // read sampled last cycle, data due now
    logic pend_rd = 1'b0;
    s_t   pend_s = '0;
    int   pend_line = 0;
    int   exp_y;

    assign error_count = errors;

    // x outside the line reads as zero
    function automatic int sample_at(int line, int s);
        if (s < 0 || s >= `LINE_SIZE)
            return 0;
        return int'(image[sg_addr_t'(line * `LINE_SIZE + s)]);
    endfunction

    // y[s] = 2 x[s] - x[s-1] - x[s+1]
    function automatic int ramp_expect(int line, int s);
        return 2 * sample_at(line, s) - sample_at(line, s - 1) - sample_at(line, s + 1);
    endfunction

    task automatic report_mismatch(string name, int expected, int actual);
        errors++;
        $display("error at %0t: %s expected %0d got %0d", $time, name, expected, actual);
    endtask

    task automatic report_failure(string what);
        errors++;
        $display("failure at %0t: %s", $time, what);
    endtask

    // everything sampled mid cycle, well away from both edges
    always @(negedge clk)
    begin
        if (!reset_n)
        begin
            // sync reset already applied by the preceding edge
            if (line_valid !== 1'b0)
                report_mismatch("line_valid", 0, int'(line_valid));
            if (done !== 1'b0)
                report_mismatch("done", 0, int'(done));
            if (next_angle_ack !== 1'b0)
                report_mismatch("next_angle_ack", 0, int'(next_angle_ack));
            if (sg_rd !== 1'b0)
                report_mismatch("sg_rd", 0, int'(sg_rd));
            if (angle !== '0)
                report_mismatch("angle", 0, int'(angle));
            read_cnt  = 0;
            burst_len = 0;
            sg_rd_q   = 1'b0;
            fill_age  = 1000;
            ack_cnt   = 0;
            exp_angle = 0;
            pend_rd   = 1'b0;
        end
        else
        begin
            // registered front bank read from last cycle
            if (pend_rd)
            begin
                exp_y = ramp_expect(pend_line, int'(pend_s));
                if (int'(rd_data) != exp_y)
                    report_mismatch("rd_data", exp_y, int'(rd_data));
            end
            pend_rd   = rd_active;
            pend_s    = rd_s;
            pend_line = int'(angle) / `ANGLE_STEP;

            if (fill_age < 1000)
                fill_age++;
            // one flat address stream per run, angle * line size + s
            if (sg_rd)
            begin
                if (!sg_rd_q)
                begin
                    fill_age  = 0;
                    burst_len = 0;
                end
                if (int'(sg_addr) != read_cnt)
                    report_mismatch("sg_addr", read_cnt, int'(sg_addr));
                read_cnt++;
                burst_len++;
            end
            else if (sg_rd_q && burst_len != `LINE_SIZE)
                report_mismatch("sg_rd burst length", `LINE_SIZE, burst_len);
            sg_rd_q = sg_rd;

            if (next_angle_ack)
            begin
                ack_cnt++;
                exp_angle += `ANGLE_STEP;
                // fill_done lands LINE_SIZE+2 cycles after the first read
                if (fill_age <= `LINE_SIZE + 2)
                    report_failure("next_angle_ack came before the back fill finished");
            end
            if (line_valid && int'(angle) != exp_angle)
                report_mismatch("angle", exp_angle, int'(angle));

            // end of a run
            if (done)
            begin
                if (ack_cnt != exp_acks)
                    report_mismatch("next_angle_ack count", exp_acks, ack_cnt);
                if (angle != exp_last_angle)
                    report_mismatch("angle", int'(exp_last_angle), int'(angle));
                if (read_cnt != `NO_OF_ANGLES * `LINE_SIZE)
                    report_mismatch("sg_rd count", `NO_OF_ANGLES * `LINE_SIZE, read_cnt);
                if (line_valid)
                    report_mismatch("line_valid", 0, int'(line_valid));
                ack_cnt   = 0;
                read_cnt  = 0;
                exp_angle = 0;
            end
        end
    end

endmodule

// File: verilog/backproj_sino_top.sv
`timescale 1ns/100ps
`include "backproj_cfg.svh"

module backproj_sino_top
    import backproj_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      kick,
    input  logic      next_angle,
    input  s_t        rd_s,
    input  sample_t   sg_data,
    output logic      done,
    output logic      line_valid,
    output angle_t    angle,
    output logic      next_angle_ack,
    output filtered_t rd_data,
    output sg_addr_t  sg_addr,
    output logic      sg_rd
);

    // sequencer to fetcher
    logic      fill_start;
    sg_addr_t  fill_base;
    // fetcher to filter
    logic      in_valid;
    logic      in_first;
    logic      in_last;
    sample_t   in_sample;
    // filter to buffer and sequencer
    logic      wr_en;
    s_t        wr_s;
    filtered_t wr_data;
    logic      fill_done;
    // sequencer to buffer
    logic      swap;

    angle_sequencer u_angle_sequencer (
        .clk            (clk),
        .reset_n        (reset_n),
        .kick           (kick),
        .next_angle     (next_angle),
        .fill_done      (fill_done),
        .angle          (angle),
        .line_valid     (line_valid),
        .next_angle_ack (next_angle_ack),
        .done           (done),
        .fill_start     (fill_start),
        .fill_base      (fill_base),
        .swap           (swap)
    );

    sino_line_fetcher u_sino_line_fetcher (
        .clk        (clk),
        .reset_n    (reset_n),
        .fill_start (fill_start),
        .fill_base  (fill_base),
        .sg_addr    (sg_addr),
        .sg_rd      (sg_rd),
        .sg_data    (sg_data),
        .in_valid   (in_valid),
        .in_first   (in_first),
        .in_last    (in_last),
        .in_sample  (in_sample)
    );

    ramp_filter u_ramp_filter (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (in_valid),
        .in_first  (in_first),
        .in_last   (in_last),
        .in_sample (in_sample),
        .wr_en     (wr_en),
        .wr_s      (wr_s),
        .wr_data   (wr_data),
        .fill_done (fill_done)
    );

    filtered_line_buffer u_filtered_line_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_s    (wr_s),
        .wr_data (wr_data),
        .swap    (swap),
        .rd_s    (rd_s),
        .rd_data (rd_data),
        .reset_n (reset_n)
    );

endmodule

// File: verilog/filtered_line_buffer.sv
`timescale 1ns/100ps
`include "backproj_cfg.svh"

module filtered_line_buffer
    import backproj_pkg::*;
(
    input  logic      clk,
    input  logic      wr_en,
    input  s_t        wr_s,
    input  filtered_t wr_data,
    input  logic      swap,
    input  s_t        rd_s,
    output filtered_t rd_data,
    input  logic      reset_n
);

    // two line banks
    filtered_t bank0 [`LINE_SIZE];
    filtered_t bank1 [`LINE_SIZE];

    // bank currently seen by the consumer
    logic front;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            front <= 1'b0;
        else if (swap)
            front <= ~front;
    end

    // filter writes always land in the back bank
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            if (front)
                bank0[wr_s] <= wr_data;
            else
                bank1[wr_s] <= wr_data;
        end
    end

    // registered read from the front bank
    always_ff @(posedge clk)
    begin
        if (front)
            rd_data <= bank1[rd_s];
        else
            rd_data <= bank0[rd_s];
    end

endmodule

// File: sino_fetch/ramp_filter.sv
`timescale 1ns/100ps
`include "backproj_cfg.svh"

module ramp_filter
    import backproj_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      in_valid,
    input  logic      in_first,
    input  logic      in_last,
    input  sample_t   in_sample,
    output logic      wr_en,
    output s_t        wr_s,
    output filtered_t wr_data,
    output logic      fill_done
);

    // x[s-1] and x[s-2] relative to the incoming sample x[s]
    sample_t   prev1;
    sample_t   prev2;
    // position of the next output
    s_t        out_pos;
    // one more output owed after the last sample
    logic      flush_pend;
    sample_t   right_x;
    filtered_t y;
    logic      emit;

    // y = 2*centre - left - right, all zero extended
    function automatic filtered_t ramp(sample_t left, sample_t centre, sample_t right);
        filtered_t l;
        filtered_t c;
        filtered_t r;
        l = filtered_t'({{(`FILTERED_WIDTH - `SAMPLE_WIDTH){1'b0}}, left});
        c = filtered_t'({{(`FILTERED_WIDTH - `SAMPLE_WIDTH){1'b0}}, centre});
        r = filtered_t'({{(`FILTERED_WIDTH - `SAMPLE_WIDTH){1'b0}}, right});
        return (c <<< 1) - l - r;
    endfunction

    // right neighbour of position 15 is outside the line
    assign right_x = flush_pend ? '0 : in_sample;
    assign y       = ramp(prev2, prev1, right_x);
    // write once per sample after the first, plus the flush
    assign emit    = flush_pend || (in_valid && !in_first);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_en      <= 1'b0;
            fill_done  <= 1'b0;
            flush_pend <= 1'b0;
            out_pos    <= '0;
        end
        else
        begin
            wr_en      <= emit;
            // line complete with the flushed write
            fill_done  <= flush_pend;
            flush_pend <= in_valid && in_last;
            if (in_valid && in_first)
                out_pos <= '0;
            else if (emit)
                out_pos <= out_pos + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        // left edge sees zero before x[0]
        if (in_valid)
        begin
            prev1 <= in_sample;
            prev2 <= in_first ? '0 : prev1;
        end
        if (emit)
        begin
            wr_s    <= out_pos;
            wr_data <= y;
        end
    end

endmodule

// File: sino_fetch/sino_line_fetcher.sv
`timescale 1ns/100ps
`include "backproj_cfg.svh"

module sino_line_fetcher
    import backproj_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     fill_start,
    input  sg_addr_t fill_base,
    output sg_addr_t sg_addr,
    output logic     sg_rd,
    input  sample_t  sg_data,
    output logic     in_valid,
    output logic     in_first,
    output logic     in_last,
    output sample_t  in_sample
);

    fetch_state_e state;

    // position s of the read currently on sg_addr
    s_t rd_cnt;

    // memory answers a cycle late, sample goes straight on
    assign in_sample = sg_data;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state  <= idle_s;
            sg_rd  <= 1'b0;
            rd_cnt <= '0;
        end
        else
        begin
            case (state)
                idle_s:
                begin
                    if (fill_start)
                    begin
                        state  <= read_s;
                        sg_rd  <= 1'b1;
                        rd_cnt <= '0;
                    end
                end
                read_s:
                begin
                    // LINE_SIZE back to back reads
                    if (rd_cnt == s_t'(`LINE_SIZE - 1))
                    begin
                        state <= flush_s;
                        sg_rd <= 1'b0;
                    end
                    else
                        rd_cnt <= rd_cnt + 1'b1;
                end
                flush_s:
                    // last sample is on sg_data now
                    state <= idle_s;
                default:
                    state <= idle_s;
            endcase
        end
    end

    // address walks with the counter
    always_ff @(posedge clk)
    begin
        if (state == idle_s)
            sg_addr <= fill_base;
        else if (state == read_s)
            sg_addr <= sg_addr + 1'b1;
    end

    // read markers delayed one cycle to meet the returned data
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            in_valid <= 1'b0;
            in_first <= 1'b0;
            in_last  <= 1'b0;
        end
        else
        begin
            in_valid <= sg_rd;
            in_first <= sg_rd && (rd_cnt == '0);
            in_last  <= sg_rd && (rd_cnt == s_t'(`LINE_SIZE - 1));
        end
    end

endmodule

// File: verilog/angle_sequencer.sv
`timescale 1ns/100ps
`include "backproj_cfg.svh"

module angle_sequencer
    import backproj_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     kick,
    input  logic     next_angle,
    input  logic     fill_done,
    output angle_t   angle,
    output logic     line_valid,
    output logic     next_angle_ack,
    output logic     done,
    output logic     fill_start,
    output sg_addr_t fill_base,
    output logic     swap
);

    seq_state_e state;

    // back bank holds the line for angle + step
    logic back_full;
    logic has_next;
    logic more_fills;
    logic advance;
    logic finish;

    // another angle exists after the one in the front bank
    assign has_next = (state == work_s) &&
                      (angle < angle_t'(`ANGLE_LIMIT - `ANGLE_STEP));

    // fill_base is the base of the last started fill
    assign more_fills = fill_base < sg_addr_t'((`NO_OF_ANGLES - 1) * `LINE_SIZE);

    // consumer done with front bank and the back line is ready
    // ack cycle itself is skipped, next_angle is still high there
    assign advance = has_next && next_angle && back_full && !next_angle_ack;

    // last angle consumed
    assign finish = (state == work_s) && !has_next && next_angle && !next_angle_ack;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state          <= ready_s;
            angle          <= '0;
            fill_base      <= '0;
            back_full      <= 1'b0;
            line_valid     <= 1'b0;
            next_angle_ack <= 1'b0;
            done           <= 1'b0;
            fill_start     <= 1'b0;
            swap           <= 1'b0;
        end
        else
        begin
            // strobes last one cycle
            fill_start     <= 1'b0;
            swap           <= 1'b0;
            next_angle_ack <= 1'b0;
            done           <= 1'b0;
            case (state)
                ready_s:
                begin
                    // start with angle 0 at sinogram base 0
                    if (kick)
                    begin
                        state      <= prime_s;
                        angle      <= '0;
                        fill_base  <= '0;
                        back_full  <= 1'b0;
                        fill_start <= 1'b1;
                    end
                end
                prime_s:
                begin
                    // first line lands, make it visible and fetch the next one
                    if (fill_done)
                    begin
                        state      <= work_s;
                        swap       <= 1'b1;
                        line_valid <= 1'b1;
                        if (more_fills)
                        begin
                            fill_base  <= fill_base + sg_addr_t'(`LINE_SIZE);
                            fill_start <= 1'b1;
                        end
                    end
                end
                work_s:
                begin
                    if (fill_done)
                        back_full <= 1'b1;
                    if (advance)
                    begin
                        // ack, swap, angle step and next fill all in one cycle
                        next_angle_ack <= 1'b1;
                        angle          <= angle + angle_t'(`ANGLE_STEP);
                        swap           <= 1'b1;
                        back_full      <= 1'b0;
                        if (more_fills)
                        begin
                            fill_base  <= fill_base + sg_addr_t'(`LINE_SIZE);
                            fill_start <= 1'b1;
                        end
                    end
                    else if (finish)
                    begin
                        done       <= 1'b1;
                        line_valid <= 1'b0;
                        state      <= ready_s;
                    end
                end
                default:
                    state <= ready_s;
            endcase
        end
    end

endmodule

// File: common/backproj_pkg.sv
`include "backproj_cfg.svh"

package backproj_pkg;

    // projection angle in degrees
    typedef logic [`ANGLE_WIDTH-1:0] angle_t;

    // detector position within a line
    typedef logic [`S_WIDTH-1:0] s_t;

    // flat sinogram memory address, angle index * line size + s
    typedef logic [`SG_ADDR_WIDTH-1:0] sg_addr_t;

    // unsigned sample from the sinogram memory
    typedef logic [`SAMPLE_WIDTH-1:0] sample_t;

    // ramp filtered sample, may go negative
    typedef logic signed [`FILTERED_WIDTH-1:0] filtered_t;

    // angle sequencer states
    // prime_s fills the very first line before anything is visible
    typedef enum logic [1:0] {
        ready_s,
        prime_s,
        work_s
    } seq_state_e;

    // line fetcher states
    // flush_s waits out the memory read latency of the last sample
    typedef enum logic [1:0] {
        idle_s,
        read_s,
        flush_s
    } fetch_state_e;

endpackage

// File: common/backproj_cfg.svh
`ifndef BACKPROJ_CFG_SVH
`define BACKPROJ_CFG_SVH

// detector samples in one projection line
`define LINE_SIZE 16

// projection angles in whole degrees
`define ANGLE_STEP 15
`define ANGLE_LIMIT 180
// 180 / 15 lines in the sinogram
`define NO_OF_ANGLES 12

// angle register, holds up to 255
`define ANGLE_WIDTH 8
// detector position, log2 of line size
`define S_WIDTH 4
// covers NO_OF_ANGLES * LINE_SIZE addresses
`define SG_ADDR_WIDTH 8

// raw sinogram samples, unsigned
`define SAMPLE_WIDTH 12
// filter output, signed
// 2*max sample needs one extra bit, sign needs one more
`define FILTERED_WIDTH 14

`endif
